// File: design/battleship_pkg.sv
package battleship_pkg;

	// Board geometry
	localparam int BOARD_SIZE = 5;          // Rows and columns per board
	localparam int MAX_SHIPS  = 5;          // Largest fleet the player may ask for
	localparam int COORD_W    = 3;          // Bits per row or column index

	// Opponent LFSR, 16 bit Galois form
	localparam logic [15:0] LFSR_SEED = 16'hACE1;   // Any nonzero start value
	localparam logic [15:0] LFSR_TAPS = 16'hB400;   // x^16 + x^14 + x^13 + x^11 + 1

	// Contents of one board cell
	typedef enum logic [1:0] {
		CELL_EMPTY,     // Water, never attacked
		CELL_SHIP,      // Ship, not yet hit
		CELL_HIT,       // Ship that was hit
		CELL_MISS       // Water that was attacked
	} cell_e;

	// Game phases
	typedef enum logic [2:0] {
		ST_DECISION,    // Player picks the fleet size
		ST_PLACEMENT,   // Player places ships with the cursor
		ST_SETUP,       // Machine places its fleet
		ST_PLAYER_TURN, // Player attacks the machine board
		ST_PC_TURN,     // Machine attacks the player board
		ST_VICTORY,     // Machine fleet gone
		ST_DEFEAT       // Player fleet gone
	} game_state_e;

endpackage

// File: design/board_if.sv
// Coordinate requests from the machine opponent to the board store
interface board_if;

	logic                               req_valid;  // Opponent offers a cell
	logic [battleship_pkg::COORD_W-1:0] req_row;    // Offered row
	logic [battleship_pkg::COORD_W-1:0] req_col;    // Offered column
	logic                               accept;     // Cell is legal, action taken this edge

	// Board side judges the cell and answers in the same cycle
	modport store (
		input  req_valid,
		input  req_row,
		input  req_col,
		output accept
	);

	// Opponent side proposes cells and retries on reject
	modport opponent (
		output req_valid,
		output req_row,
		output req_col,
		input  accept
	);

endinterface

// File: design/game_fsm.sv
module game_fsm (
	input  logic                        clk,
	input  logic                        i_reset,
	input  logic                        i_count_done,       // Fleet size stored
	input  logic                        i_placement_done,   // Last player ship placed
	input  logic                        i_setup_done,       // Last machine ship placed
	input  logic                        i_player_attacked,  // Player attack resolved
	input  logic                        i_pc_attacked,      // Machine attack resolved
	input  logic                        i_pc_fleet_zero,    // Machine fleet just sunk
	input  logic                        i_player_fleet_zero,
	output battleship_pkg::game_state_e o_state
);

	battleship_pkg::game_state_e state_d;

	// Next phase from the event pulses
	always_comb begin
		state_d = o_state; // Hold by default
		case (o_state)
			battleship_pkg::ST_DECISION: begin
				if (i_count_done) state_d = battleship_pkg::ST_PLACEMENT;
			end
			battleship_pkg::ST_PLACEMENT: begin
				if (i_placement_done) state_d = battleship_pkg::ST_SETUP;
			end
			battleship_pkg::ST_SETUP: begin
				if (i_setup_done) state_d = battleship_pkg::ST_PLAYER_TURN;
			end
			battleship_pkg::ST_PLAYER_TURN: begin
				// Sinking the last ship wins over handing the turn over
				if (i_pc_fleet_zero) begin
					state_d = battleship_pkg::ST_VICTORY;
				end else if (i_player_attacked) begin
					state_d = battleship_pkg::ST_PC_TURN;
				end
			end
			battleship_pkg::ST_PC_TURN: begin
				if (i_player_fleet_zero) begin
					state_d = battleship_pkg::ST_DEFEAT;
				end else if (i_pc_attacked) begin
					state_d = battleship_pkg::ST_PLAYER_TURN;
				end
			end
			default: state_d = o_state; // End states wait for reset
		endcase
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_state <= battleship_pkg::ST_DECISION;
		end else begin
			o_state <= state_d;
		end
	end

	// A finished game stays finished until reset
	end_state_held: assert property (@(posedge clk) disable iff (i_reset)
		(o_state inside {battleship_pkg::ST_VICTORY, battleship_pkg::ST_DEFEAT})
		|=> (o_state == $past(o_state)));

endmodule

// File: design/cursor_ctrl.sv
module cursor_ctrl (
	input  logic                               clk,
	input  logic                               i_reset,
	input  battleship_pkg::game_state_e        i_state,
	input  logic                               i_up,      // Row minus one
	input  logic                               i_down,    // Row plus one
	input  logic                               i_left,    // Column minus one
	input  logic                               i_right,   // Column plus one
	output logic [battleship_pkg::COORD_W-1:0] o_row,
	output logic [battleship_pkg::COORD_W-1:0] o_col
);

	battleship_pkg::game_state_e state_q;  // Phase seen last cycle
	logic                        move_ok;  // Phases that own the cursor
	logic                        entering; // First cycle of such a phase

	assign move_ok  = (i_state == battleship_pkg::ST_PLACEMENT) ||
		(i_state == battleship_pkg::ST_PLAYER_TURN);
	assign entering = move_ok && (i_state != state_q);

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state_q <= battleship_pkg::ST_DECISION;
			o_row   <= '0;
			o_col   <= '0;
		end else begin
			state_q <= i_state;
			if (entering) begin
				o_row <= '0; // Back to top left corner
				o_col <= '0;
			end else if (move_ok) begin
				// Each direction saturates at its own edge
				if (i_up && o_row != '0) o_row <= o_row - 1'b1;
				else if (i_down && o_row < battleship_pkg::BOARD_SIZE - 1) o_row <= o_row + 1'b1;
				if (i_left && o_col != '0) o_col <= o_col - 1'b1;
				else if (i_right && o_col < battleship_pkg::BOARD_SIZE - 1) o_col <= o_col + 1'b1;
			end
		end
	end

	cursor_on_board: assert property (@(posedge clk) disable iff (i_reset)
		(o_row < battleship_pkg::BOARD_SIZE) && (o_col < battleship_pkg::BOARD_SIZE));

endmodule

// File: design/board_store.sv
module board_store (
	input  logic                               clk,
	input  logic                               i_reset,
	input  battleship_pkg::game_state_e        i_state,
	input  logic [2:0]                         i_ship_count,    // Raw fleet size from switches
	input  logic                               i_confirm_count,
	input  logic                               i_place,
	input  logic                               i_attack,
	input  logic [battleship_pkg::COORD_W-1:0] i_row,           // Player cursor
	input  logic [battleship_pkg::COORD_W-1:0] i_col,
	board_if.store                             opp,
	output logic [2:0]                         o_fleet_size,
	output logic [2:0]                         o_ships_left_player,
	output logic [2:0]                         o_ships_left_pc,
	output logic                               o_placement_error,
	output logic                               o_last_hit,      // Player shot hit, one cycle
	output logic                               o_count_done,
	output logic                               o_placement_done,
	output logic                               o_setup_done,
	output logic                               o_player_attacked,
	output logic                               o_pc_attacked,
	output logic                               o_pc_fleet_zero,
	output logic                               o_player_fleet_zero
);

	battleship_pkg::cell_e player_board [battleship_pkg::BOARD_SIZE][battleship_pkg::BOARD_SIZE];
	battleship_pkg::cell_e pc_board [battleship_pkg::BOARD_SIZE][battleship_pkg::BOARD_SIZE];

	logic [2:0]            clamped_count;
	logic                  event_pending; // Phase change already on its way
	logic                  opp_legal;
	battleship_pkg::cell_e cur_player_cell;  // Cells under the player cursor
	battleship_pkg::cell_e cur_pc_cell;
	battleship_pkg::cell_e req_player_cell;  // Cells offered by the opponent
	battleship_pkg::cell_e req_pc_cell;

	// Fleet size limited to one through MAX_SHIPS
	always_comb begin
		if (i_ship_count == 3'd0) clamped_count = 3'd1;
		else if (i_ship_count > battleship_pkg::MAX_SHIPS) clamped_count = 3'(battleship_pkg::MAX_SHIPS);
		else clamped_count = i_ship_count;
	end

	assign cur_player_cell = player_board[i_row][i_col];
	assign cur_pc_cell     = pc_board[i_row][i_col];
	assign req_player_cell = player_board[opp.req_row][opp.req_col];
	assign req_pc_cell     = pc_board[opp.req_row][opp.req_col];

	// The FSM moves one cycle after an event, so block actions in between
	assign event_pending = o_count_done | o_placement_done | o_setup_done |
		o_player_attacked | o_pc_attacked;

	// Legality of the opponent's cell depends on the phase
	always_comb begin
		opp_legal = 1'b0;
		case (i_state)
			battleship_pkg::ST_SETUP: opp_legal = (req_pc_cell == battleship_pkg::CELL_EMPTY) &&
				(o_ships_left_pc < o_fleet_size);
			battleship_pkg::ST_PC_TURN: opp_legal = (req_player_cell == battleship_pkg::CELL_EMPTY) ||
				(req_player_cell == battleship_pkg::CELL_SHIP);
			default: opp_legal = 1'b0;
		endcase
	end

	assign opp.accept = opp.req_valid && opp_legal && !event_pending;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			for (int r = 0; r < battleship_pkg::BOARD_SIZE; r++) begin
				for (int c = 0; c < battleship_pkg::BOARD_SIZE; c++) begin
					player_board[r][c] <= battleship_pkg::CELL_EMPTY;
					pc_board[r][c]     <= battleship_pkg::CELL_EMPTY;
				end
			end
			o_fleet_size        <= '0;
			o_ships_left_player <= '0;
			o_ships_left_pc     <= '0;
			o_placement_error   <= 1'b0;
			o_last_hit          <= 1'b0;
			o_count_done        <= 1'b0;
			o_placement_done    <= 1'b0;
			o_setup_done        <= 1'b0;
			o_player_attacked   <= 1'b0;
			o_pc_attacked       <= 1'b0;
			o_pc_fleet_zero     <= 1'b0;
			o_player_fleet_zero <= 1'b0;
		end else begin
			// Pulses last one cycle
			o_last_hit          <= 1'b0;
			o_count_done        <= 1'b0;
			o_placement_done    <= 1'b0;
			o_setup_done        <= 1'b0;
			o_player_attacked   <= 1'b0;
			o_pc_attacked       <= 1'b0;
			o_pc_fleet_zero     <= 1'b0;
			o_player_fleet_zero <= 1'b0;
			case (i_state)
				battleship_pkg::ST_DECISION: begin
					if (i_confirm_count && !event_pending) begin
						o_fleet_size <= clamped_count;
						o_count_done <= 1'b1;
					end
				end
				battleship_pkg::ST_PLACEMENT: begin
					if (i_place && !event_pending) begin
						if (cur_player_cell == battleship_pkg::CELL_SHIP) begin
							o_placement_error <= 1'b1; // Occupied, nothing written
						end else begin
							o_placement_error           <= 1'b0;
							player_board[i_row][i_col] <= battleship_pkg::CELL_SHIP;
							o_ships_left_player        <= o_ships_left_player + 3'd1;
							if (o_ships_left_player + 3'd1 == o_fleet_size) o_placement_done <= 1'b1;
						end
					end
				end
				battleship_pkg::ST_SETUP: begin
					if (opp.accept) begin
						pc_board[opp.req_row][opp.req_col] <= battleship_pkg::CELL_SHIP;
						o_ships_left_pc <= o_ships_left_pc + 3'd1;
						if (o_ships_left_pc + 3'd1 == o_fleet_size) o_setup_done <= 1'b1;
					end
				end
				battleship_pkg::ST_PLAYER_TURN: begin
					// Cells already hit or missed are ignored
					if (i_attack && !event_pending && (cur_pc_cell == battleship_pkg::CELL_EMPTY ||
						cur_pc_cell == battleship_pkg::CELL_SHIP)) begin
						o_player_attacked <= 1'b1;
						if (cur_pc_cell == battleship_pkg::CELL_SHIP) begin
							pc_board[i_row][i_col] <= battleship_pkg::CELL_HIT;
							o_last_hit             <= 1'b1;
							o_ships_left_pc        <= o_ships_left_pc - 3'd1;
							if (o_ships_left_pc == 3'd1) o_pc_fleet_zero <= 1'b1; // Last ship sunk
						end else begin
							pc_board[i_row][i_col] <= battleship_pkg::CELL_MISS;
						end
					end
				end
				battleship_pkg::ST_PC_TURN: begin
					if (opp.accept) begin
						o_pc_attacked <= 1'b1;
						if (req_player_cell == battleship_pkg::CELL_SHIP) begin
							player_board[opp.req_row][opp.req_col] <= battleship_pkg::CELL_HIT;
							o_ships_left_player <= o_ships_left_player - 3'd1;
							if (o_ships_left_player == 3'd1) o_player_fleet_zero <= 1'b1;
						end else begin
							player_board[opp.req_row][opp.req_col] <= battleship_pkg::CELL_MISS;
						end
					end
				end
				default: ; // End states freeze both boards
			endcase
		end
	end

	// Opponent handshake seen from the store side
	accept_needs_valid: assert property (@(posedge clk) disable iff (i_reset)
		opp.accept |-> opp.req_valid);

endmodule

// File: design/pc_opponent.sv
module pc_opponent (
	input  logic                        clk,
	input  logic                        i_reset,
	input  battleship_pkg::game_state_e i_state,
	board_if.opponent                   opp
);

	logic [15:0] lfsr_q;
	logic [15:0] lfsr_d;
	logic        field_sel_q; // Swaps field pairs after each accepted cell
	logic [2:0]  row_raw;
	logic [2:0]  col_raw;
	int unsigned row_mod;
	int unsigned col_mod;

	// Requests only while the machine has work to do
	assign opp.req_valid = (i_state == battleship_pkg::ST_SETUP) ||
		(i_state == battleship_pkg::ST_PC_TURN);

	// Galois step, shift right and fold taps in when bit 0 falls out
	assign lfsr_d = lfsr_q[0] ? ((lfsr_q >> 1) ^ battleship_pkg::LFSR_TAPS) : (lfsr_q >> 1);

	// Two 3 bit fields per coordinate
	always_comb begin
		if (field_sel_q) begin
			row_raw = lfsr_q[6:4];
			col_raw = lfsr_q[14:12];
		end else begin
			row_raw = lfsr_q[2:0];
			col_raw = lfsr_q[10:8];
		end
		row_mod = row_raw % battleship_pkg::BOARD_SIZE; // Fold 5..7 back onto the board
		col_mod = col_raw % battleship_pkg::BOARD_SIZE;
	end

	assign opp.req_row = row_mod[battleship_pkg::COORD_W-1:0];
	assign opp.req_col = col_mod[battleship_pkg::COORD_W-1:0];

	always_ff @(posedge clk) begin
		if (i_reset) begin
			lfsr_q      <= battleship_pkg::LFSR_SEED;
			field_sel_q <= 1'b0;
		end else begin
			if (opp.req_valid) lfsr_q <= lfsr_d; // Fresh cell every cycle, accepted or not
			if (opp.accept) field_sel_q <= ~field_sel_q;
		end
	end

endmodule

// File: design/seg7_decoder.sv
module seg7_decoder (
	input  logic [2:0] i_value,
	output logic [6:0] o_seg    // {g,f,e,d,c,b,a}, low lights the segment
);

	always_comb begin
		case (i_value)
			3'd0: o_seg = 7'b1000000;
			3'd1: o_seg = 7'b1111001;
			3'd2: o_seg = 7'b0100100;
			3'd3: o_seg = 7'b0110000;
			3'd4: o_seg = 7'b0011001;
			3'd5: o_seg = 7'b0010010;
			3'd6: o_seg = 7'b0000010;
			3'd7: o_seg = 7'b1111000;
			default: o_seg = 7'b1111111; // All dark
		endcase
	end

endmodule

// File: design/battleship_top.sv
module battleship_top (
	input  logic       clk,
	input  logic       i_reset,
	input  logic       i_move_up,
	input  logic       i_move_down,
	input  logic       i_move_left,
	input  logic       i_move_right,
	input  logic [2:0] i_ship_count,
	input  logic       i_confirm_count,
	input  logic       i_place,
	input  logic       i_attack,
	output logic       o_placement_error,
	output logic       o_last_hit,
	output logic [6:0] o_fleet_seg,
	output logic [6:0] o_ships_left_player_seg,
	output logic [6:0] o_ships_left_pc_seg,
	output logic       o_decision_state,
	output logic       o_placement_state,
	output logic       o_setup_state,
	output logic       o_player_turn_state,
	output logic       o_pc_turn_state,
	output logic       o_victory_state,
	output logic       o_defeat_state
);

	battleship_pkg::game_state_e        state;
	logic [battleship_pkg::COORD_W-1:0] cur_row;
	logic [battleship_pkg::COORD_W-1:0] cur_col;
	logic [2:0]                         fleet_size;
	logic [2:0]                         ships_left_player;
	logic [2:0]                         ships_left_pc;
	logic                               count_done;
	logic                               placement_done;
	logic                               setup_done;
	logic                               player_attacked;
	logic                               pc_attacked;
	logic                               pc_fleet_zero;
	logic                               player_fleet_zero;

	board_if opp_bus (); // Machine opponent to board store

	game_fsm game_fsm_i (
		.clk                 (clk),
		.i_reset             (i_reset),
		.i_count_done        (count_done),
		.i_placement_done    (placement_done),
		.i_setup_done        (setup_done),
		.i_player_attacked   (player_attacked),
		.i_pc_attacked       (pc_attacked),
		.i_pc_fleet_zero     (pc_fleet_zero),
		.i_player_fleet_zero (player_fleet_zero),
		.o_state             (state)
	);

	cursor_ctrl cursor_ctrl_i (
		.clk     (clk),
		.i_reset (i_reset),
		.i_state (state),
		.i_up    (i_move_up),
		.i_down  (i_move_down),
		.i_left  (i_move_left),
		.i_right (i_move_right),
		.o_row   (cur_row),
		.o_col   (cur_col)
	);

	board_store board_store_i (
		.clk                 (clk),
		.i_reset             (i_reset),
		.i_state             (state),
		.i_ship_count        (i_ship_count),
		.i_confirm_count     (i_confirm_count),
		.i_place             (i_place),
		.i_attack            (i_attack),
		.i_row               (cur_row),
		.i_col               (cur_col),
		.opp                 (opp_bus.store),
		.o_fleet_size        (fleet_size),
		.o_ships_left_player (ships_left_player),
		.o_ships_left_pc     (ships_left_pc),
		.o_placement_error   (o_placement_error),
		.o_last_hit          (o_last_hit),
		.o_count_done        (count_done),
		.o_placement_done    (placement_done),
		.o_setup_done        (setup_done),
		.o_player_attacked   (player_attacked),
		.o_pc_attacked       (pc_attacked),
		.o_pc_fleet_zero     (pc_fleet_zero),
		.o_player_fleet_zero (player_fleet_zero)
	);

	pc_opponent pc_opponent_i (
		.clk     (clk),
		.i_reset (i_reset),
		.i_state (state),
		.opp     (opp_bus.opponent)
	);

	// Fleet size and remaining ships on the three digits
	seg7_decoder fleet_seg_i         (.i_value(fleet_size),        .o_seg(o_fleet_seg));
	seg7_decoder player_left_seg_i   (.i_value(ships_left_player), .o_seg(o_ships_left_player_seg));
	seg7_decoder pc_left_seg_i       (.i_value(ships_left_pc),     .o_seg(o_ships_left_pc_seg));

	// One-hot phase lamps
	assign o_decision_state    = (state == battleship_pkg::ST_DECISION);
	assign o_placement_state   = (state == battleship_pkg::ST_PLACEMENT);
	assign o_setup_state       = (state == battleship_pkg::ST_SETUP);
	assign o_player_turn_state = (state == battleship_pkg::ST_PLAYER_TURN);
	assign o_pc_turn_state     = (state == battleship_pkg::ST_PC_TURN);
	assign o_victory_state     = (state == battleship_pkg::ST_VICTORY);
	assign o_defeat_state      = (state == battleship_pkg::ST_DEFEAT);

endmodule

// File: verif/battleship_checker.sv
module battleship_checker (
	input  logic         clk,
	input  logic         i_reset,
	input  logic         i_check,       // Compare the masked fields this cycle
	input  logic [127:0] i_name,        // Name of the running table row
	input  logic [5:0]   i_mask,        // {hit, error, pc, player, fleet, phase}
	input  logic [6:0]   i_exp_phase,
	input  logic [2:0]   i_exp_fleet,
	input  logic [2:0]   i_exp_player,
	input  logic [2:0]   i_exp_pc,
	input  logic         i_exp_error,
	input  logic         i_exp_hit,
	input  logic [6:0]   i_phase,       // {defeat, victory, pc, player, setup, place, decision}
	input  logic         i_placement_error,
	input  logic         i_last_hit,
	input  logic [6:0]   i_fleet_seg,
	input  logic [6:0]   i_player_seg,
	input  logic [6:0]   i_pc_seg,
	output int           o_checks,
	output int           o_errors
);

	timeunit 1ns;
	timeprecision 100ps;

	int   fleet;
	int   player;
	int   pc;
	int   prev_player;
	int   prev_pc;
	logic prev_in_play;  // Last sample was a player or machine turn
	logic prev_pc_turn;
	logic armed;         // Play has started since reset

	// Active-low digit back to a count, 8 marks a pattern that is no digit
	function automatic int seg_count(input logic [6:0] seg);
		case (seg)
			7'b1000000: return 0;
			7'b1111001: return 1;
			7'b0100100: return 2;
			7'b0110000: return 3;
			7'b0011001: return 4;
			7'b0010010: return 5;
			7'b0000010: return 6;
			7'b1111000: return 7;
			default:    return 8;
		endcase
	endfunction

	task automatic report(input string what, input int exp, input int act);
		o_errors++;
		$display("ERROR %0s: %0s expected %0h, actual %0h", i_name, what, exp, act);
	endtask

	initial begin
		o_checks = 0;
		o_errors = 0;
	end

	// Outputs settle after the rising edge, sample them in mid cycle
	always @(negedge clk) begin
		fleet  = seg_count(i_fleet_seg);
		player = seg_count(i_player_seg);
		pc     = seg_count(i_pc_seg);
		if (i_check) begin
			o_checks++;
			if (i_mask[0] && i_phase != i_exp_phase) report("phase", i_exp_phase, i_phase);
			if (i_mask[1] && fleet != i_exp_fleet) report("fleet size", i_exp_fleet, fleet);
			if (i_mask[2] && player != i_exp_player) report("player ships", i_exp_player, player);
			if (i_mask[3] && pc != i_exp_pc) report("machine ships", i_exp_pc, pc);
			if (i_mask[4] && i_placement_error != i_exp_error)
				report("placement error", i_exp_error, i_placement_error);
			if (i_mask[5] && i_last_hit != i_exp_hit) report("last hit", i_exp_hit, i_last_hit);
		end
		if (i_reset) begin
			armed        = 1'b0;
			prev_in_play = 1'b0;
			prev_pc_turn = 1'b0;
		end else begin
			if (i_phase == 7'd0 || (i_phase & (i_phase - 7'd1)) != 7'd0) begin
				o_errors++;
				$display("Phase outputs are not one-hot in %0s: %b", i_name, i_phase);
			end
			if (prev_in_play) begin
				// Machine count moves only with a player hit
				if (i_last_hit && pc != prev_pc - 1) report("machine ships on hit", prev_pc - 1, pc);
				if (!i_last_hit && pc != prev_pc) report("machine ships", prev_pc, pc);
				if (player > prev_player || prev_player - player > 1 ||
					(player != prev_player && !prev_pc_turn))
					report("player ships", prev_player, player);
			end
			if (armed && i_phase[5] && pc != 0) report("machine ships at victory", 0, pc);
			if (armed && i_phase[6] && player != 0) report("player ships at defeat", 0, player);
			if (armed && prev_pc == 0 && pc == 0) begin
				if (!i_phase[5]) report("victory", 1, i_phase[5]);
			end
			if (armed && prev_player == 0 && player == 0) begin
				if (!i_phase[6]) report("defeat", 1, i_phase[6]);
			end
			prev_in_play = i_phase[3] | i_phase[4];
			prev_pc_turn = i_phase[4];
			if (i_phase[3]) armed = 1'b1;
		end
		prev_pc     = pc;
		prev_player = player;
	end

endmodule

// File: verif/tb_battleship.sv
module tb_battleship;

	timeunit 1ns;
	timeprecision 100ps;

	typedef enum logic [3:0] {
		OP_RESET, OP_CONFIRM, OP_MOVE, OP_PLACE, OP_ATTACK, OP_ROUND, OP_WAIT, OP_IDLE, OP_SWEEP
	} op_e;

	// One table row, arg meaning depends on op
	typedef struct packed {
		logic [127:0] name;
		op_e          op;
		logic [7:0]   arg;    // MOVE: {repeats, right left down up}
		logic [5:0]   mask;
		logic [6:0]   phase;
		logic [2:0]   fleet;
		logic [2:0]   player;
		logic [2:0]   pc;
		logic         error;
		logic         hit;
	} step_t;

	localparam int         NUM_STEPS = 23;
	localparam int         TURN_LIMIT = 2000;  // Machine retries until a legal cell
	localparam int         EDGE_LIMIT = 8;
	localparam logic [5:0] M_PH = 6'd1, M_FL = 6'd2, M_PL = 6'd4, M_PC = 6'd8;
	localparam logic [5:0] M_ER = 6'd16, M_HT = 6'd32, M_ALL = 6'h3F, M_NONE = 6'd0;
	localparam logic [6:0] PH_DEC = 7'h01, PH_PLC = 7'h02, PH_PT = 7'h08;
	localparam logic [6:0] PH_VIC = 7'h20, PH_DEF = 7'h40;

	logic         clk;
	logic         reset;
	logic [6:0]   btn;         // {attack, place, confirm, right, left, down, up}
	logic [2:0]   ship_count;
	logic         placement_error, last_hit;
	logic [6:0]   fleet_seg, player_seg, pc_seg;
	logic [6:0]   phase_now;
	logic         dec_st, plc_st, setup_st, pt_st, pc_st, vic_st, def_st;
	logic         chk_valid;
	logic [127:0] cur_name;
	step_t        chk_step;
	step_t        steps [NUM_STEPS];
	int           checks, errors, fails;

	assign phase_now = {def_st, vic_st, pc_st, pt_st, setup_st, plc_st, dec_st};

	battleship_top battleship_top_i (
		.clk(clk), .i_reset(reset),
		.i_move_up(btn[0]), .i_move_down(btn[1]), .i_move_left(btn[2]), .i_move_right(btn[3]),
		.i_ship_count(ship_count), .i_confirm_count(btn[4]), .i_place(btn[5]), .i_attack(btn[6]),
		.o_placement_error(placement_error), .o_last_hit(last_hit),
		.o_fleet_seg(fleet_seg), .o_ships_left_player_seg(player_seg),
		.o_ships_left_pc_seg(pc_seg),
		.o_decision_state(dec_st), .o_placement_state(plc_st), .o_setup_state(setup_st),
		.o_player_turn_state(pt_st), .o_pc_turn_state(pc_st),
		.o_victory_state(vic_st), .o_defeat_state(def_st)
	);

	battleship_checker checker_i (
		.clk(clk), .i_reset(reset), .i_check(chk_valid), .i_name(cur_name),
		.i_mask(chk_step.mask), .i_exp_phase(chk_step.phase), .i_exp_fleet(chk_step.fleet),
		.i_exp_player(chk_step.player), .i_exp_pc(chk_step.pc),
		.i_exp_error(chk_step.error), .i_exp_hit(chk_step.hit), .i_phase(phase_now),
		.i_placement_error(placement_error), .i_last_hit(last_hit),
		.i_fleet_seg(fleet_seg), .i_player_seg(player_seg), .i_pc_seg(pc_seg),
		.o_checks(checks), .o_errors(errors)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic load_table();
		steps[0]  = '{"reset_idle", OP_RESET, 8'h00, M_ALL, PH_DEC, 3'd0, 3'd0, 3'd0, 1'b0, 1'b0};
		steps[1]  = '{"clamp_zero", OP_CONFIRM, 8'h00, M_FL, PH_DEC, 3'd1, 3'd0, 3'd0, 1'b0, 1'b0};
		steps[2]  = '{"reset_two", OP_RESET, 8'h00, M_PH, PH_DEC, 3'd0, 3'd0, 3'd0, 1'b0, 1'b0};
		steps[3]  = '{"clamp_seven", OP_CONFIRM, 8'h07, M_FL, PH_DEC, 3'd5, 3'd0, 3'd0, 1'b0, 1'b0};
		steps[4]  = '{"reset_three", OP_RESET, 8'h00, M_PH | M_FL, PH_DEC, 3'd0, 3'd0, 3'd0, 1'b0, 1'b0};
		steps[5]  = '{"clamp_three", OP_CONFIRM, 8'h03, M_FL, PH_DEC, 3'd3, 3'd0, 3'd0, 1'b0, 1'b0};
		steps[6]  = '{"enter_place", OP_WAIT, 8'h01, M_PH, PH_PLC, 3'd3, 3'd0, 3'd0, 1'b0, 1'b0};
		steps[7]  = '{"place_first", OP_PLACE, 8'h00, M_ER | M_PL, PH_PLC, 3'd3, 3'd1, 3'd0, 1'b0, 1'b0};
		steps[8]  = '{"place_twice", OP_PLACE, 8'h00, M_ER | M_PL, PH_PLC, 3'd3, 3'd1, 3'd0, 1'b1, 1'b0};
		steps[9]  = '{"corner_move", OP_MOVE, 8'h25, M_NONE, PH_PLC, 3'd3, 3'd1, 3'd0, 1'b0, 1'b0};
		steps[10] = '{"place_corner", OP_PLACE, 8'h00, M_ER | M_PL, PH_PLC, 3'd3, 3'd1, 3'd0, 1'b1, 1'b0};
		steps[11] = '{"far_move", OP_MOVE, 8'h7A, M_NONE, PH_PLC, 3'd3, 3'd1, 3'd0, 1'b0, 1'b0};
		steps[12] = '{"place_far", OP_PLACE, 8'h00, M_ER | M_PL, PH_PLC, 3'd3, 3'd2, 3'd0, 1'b0, 1'b0};
		steps[13] = '{"past_far", OP_MOVE, 8'h2A, M_NONE, PH_PLC, 3'd3, 3'd2, 3'd0, 1'b0, 1'b0};
		steps[14] = '{"place_past", OP_PLACE, 8'h00, M_ER | M_PL, PH_PLC, 3'd3, 3'd2, 3'd0, 1'b1, 1'b0};
		steps[15] = '{"step_left", OP_MOVE, 8'h14, M_NONE, PH_PLC, 3'd3, 3'd2, 3'd0, 1'b0, 1'b0};
		steps[16] = '{"place_last", OP_PLACE, 8'h00, M_ER | M_PL, PH_PLC, 3'd3, 3'd3, 3'd0, 1'b0, 1'b0};
		steps[17] = '{"setup_wait", OP_WAIT, 8'h03, M_PH | M_FL | M_PL | M_PC, PH_PT,
			3'd3, 3'd3, 3'd3, 1'b0, 1'b0};
		steps[18] = '{"first_round", OP_ROUND, 8'h00, M_PH, PH_PT, 3'd3, 3'd0, 3'd0, 1'b0, 1'b0};
		steps[19] = '{"repeat_attack", OP_ATTACK, 8'h00, M_PH | M_HT, PH_PT, 3'd3, 3'd0, 3'd0, 1'b0, 1'b0};
		steps[20] = '{"repeat_hold", OP_IDLE, 8'h00, M_PH, PH_PT, 3'd3, 3'd0, 3'd0, 1'b0, 1'b0};
		steps[21] = '{"sweep", OP_SWEEP, 8'h01, M_NONE, PH_PT, 3'd3, 3'd0, 3'd0, 1'b0, 1'b0};
		steps[22] = '{"end_hold", OP_IDLE, 8'h04, M_NONE, PH_VIC, 3'd3, 3'd0, 3'd0, 1'b0, 1'b0};
	endtask

	// One-cycle button pulse, acted on at the edge after it is driven
	task automatic press(input logic [6:0] which);
		@(posedge clk);
		btn <= which;
		@(posedge clk);
		btn <= '0;
	endtask

	// Phase is looked at in mid cycle where it is settled
	task automatic wait_phase(input logic [6:0] any_of, input int limit, output logic ok);
		int n;
		n  = 0;
		ok = 1'b0;
		while (!ok && n < limit) begin
			@(negedge clk);
			n++;
			ok = |(phase_now & any_of);
		end
		if (!ok) begin
			fails++;
			$display("Timeout in %0s: no phase of %b within %0d cycles", cur_name, any_of, limit);
		end
	endtask

	// Player shot, then the machine's answer if the game goes on
	task automatic play_round(output logic over);
		logic ok;
		press(7'b1000000);
		wait_phase(~PH_PT, EDGE_LIMIT, ok);
		if (ok && phase_now[4]) wait_phase(PH_PT | PH_VIC | PH_DEF, TURN_LIMIT, ok);
		over = phase_now[5] | phase_now[6];
	endtask

	task automatic sweep(input int start);
		logic over;
		int   r;
		int   c;
		int   moves;
		over = 1'b0;
		for (int idx = start; idx < 25 && !over; idx++) begin
			r     = idx / battleship_pkg::BOARD_SIZE;
			c     = idx % battleship_pkg::BOARD_SIZE;
			moves = (r > c) ? r : c;
			// Cursor is back at the origin on every player turn
			for (int k = 0; k < moves; k++) press({3'b000, k < c, 1'b0, k < r, 1'b0});
			play_round(over);
		end
		if (!over) begin
			fails++;
			$display("Sweep finished without victory or defeat");
		end
	endtask

	task automatic run_step(input step_t s);
		logic ok;
		logic over;
		cur_name <= s.name;
		case (s.op)
			OP_RESET: begin
				@(posedge clk);
				reset <= 1'b1;
				repeat (2) @(posedge clk);
				reset <= 1'b0;
			end
			OP_CONFIRM: begin
				ship_count <= s.arg[2:0];
				press(7'b0010000);
			end
			OP_MOVE:   repeat (s.arg[7:4]) press({3'b000, s.arg[3:0]});
			OP_PLACE:  press(7'b0100000);
			OP_ATTACK: press(7'b1000000);
			OP_ROUND:  play_round(over);
			OP_WAIT:   wait_phase(7'd1 << s.arg, TURN_LIMIT, ok);
			OP_IDLE:   repeat (s.arg) @(posedge clk);
			OP_SWEEP:  sweep(s.arg);
			default:   ;
		endcase
		if (s.mask != M_NONE) begin
			// Waits end in mid cycle, the check strobe starts on an edge
			if (s.op == OP_WAIT || s.op == OP_ROUND) @(posedge clk);
			chk_step  <= s;
			chk_valid <= 1'b1;
			@(posedge clk);
			chk_valid <= 1'b0;
		end
	endtask

	initial begin
		reset      = 1'b1;
		btn        = '0;
		ship_count = 3'd0;
		chk_valid  = 1'b0;
		chk_step   = '0;
		cur_name   = '0;
		fails      = 0;
		load_table();
		for (int i = 0; i < NUM_STEPS; i++) run_step(steps[i]);
		repeat (2) @(posedge clk);
		$display("Checks %0d, errors %0d, other failures %0d", checks, errors, fails);
		if (errors == 0 && fails == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: build.f
design/battleship_pkg.sv
design/board_if.sv
design/game_fsm.sv
design/cursor_ctrl.sv
design/board_store.sv
design/pc_opponent.sv
design/seg7_decoder.sv
design/battleship_top.sv
verif/battleship_checker.sv
verif/tb_battleship.sv

// File: Bender.yml
package:
  name: battleship

sources:
  - design/battleship_pkg.sv
  - design/board_if.sv
  - design/game_fsm.sv
  - design/cursor_ctrl.sv
  - design/board_store.sv
  - design/pc_opponent.sv
  - design/seg7_decoder.sv
  - design/battleship_top.sv
  - target: test
    files:
      - verif/battleship_checker.sv
      - verif/tb_battleship.sv
